//--- hw/psram_pkg.sv
`default_nettype none

package psram_pkg;

    // Device command codes
    localparam logic [7:0] CMD_QUAD_ENTER = 8'h35;
    localparam logic [7:0] CMD_QUAD_READ  = 8'h EB;
    localparam logic [7:0] CMD_QUAD_WRITE = 8'h38;

    // Device geometry
    localparam int ADDR_W = 24;

    // Serial enter-quad command length in sck periods
    localparam int INIT_BITS = 8;

    // Quad phase lengths in nibbles, one nibble per sck period
    localparam int CMD_NIBBLES  = 2;
    localparam int ADDR_NIBBLES = ADDR_W / 4;
    localparam int READ_DUMMY   = 6;
    localparam int WORD_NIBBLES = 8;

    // Reader phase boundaries
    localparam int RD_DATA_FIRST = CMD_NIBBLES + ADDR_NIBBLES + READ_DUMMY;
    localparam int RD_LAST_NIB   = RD_DATA_FIRST + WORD_NIBBLES - 1;

    // Nibble counter width, wide enough for the longest transfer
    localparam int NIB_W = 5;

    typedef enum logic [1:0] {
        ST_INIT = 2'd0,
        ST_IDLE = 2'd1,
        ST_WAIT = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/psram_io_if.sv
`timescale 1ns/1ps
`default_nettype none

// Pin-level bundle of one PSRAM bus driver
interface psram_io_if;

    logic       sck;
    logic       ce_n;
    logic [3:0] dout;
    // Single enable for all four data lines
    logic       douten;
    logic [3:0] din;

    modport phy (
        output sck,
        output ce_n,
        output dout,
        output douten,
        input  din
    );

    modport mux (
        input  sck,
        input  ce_n,
        input  dout,
        input  douten,
        output din
    );

endinterface

`default_nettype wire

//--- hw/psram_qpi_init.sv
`timescale 1ns/1ps
`default_nettype none

// Sends the enter-quad command in SPI mode right after reset
module psram_qpi_init
    import psram_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    psram_io_if.phy io,
    output logic    init_done_o
);

    logic [7:0]                   cmd_sh;
    logic [$clog2(INIT_BITS)-1:0] bit_cnt;
    logic                         sck_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            cmd_sh      <= CMD_QUAD_ENTER;
            bit_cnt     <= '0;
            sck_q       <= 1'b0;
            init_done_o <= 1'b0;
        end else if (!init_done_o) begin
            sck_q <= ~sck_q;
            // Next bit goes out as sck falls
            if (sck_q) begin
                cmd_sh <= {cmd_sh[6:0], 1'b0};
                if (bit_cnt == ($clog2(INIT_BITS))'(INIT_BITS - 1)) begin
                    init_done_o <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Command stays selected for the whole sequence, MSB first on line 0
    assign io.sck    = sck_q;
    assign io.ce_n   = init_done_o;
    assign io.dout   = {3'b000, cmd_sh[7]};
    assign io.douten = 1'b1;

endmodule

`default_nettype wire

//--- hw/psram_reader.sv
`timescale 1ns/1ps
`default_nettype none

// Quad fast read (EBh) of one 32-bit word
module psram_reader
    import psram_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  logic [ADDR_W-1:0] addr_i,
    output logic              done_o,
    output logic [31:0]       data_o,
    psram_io_if.phy           io
);

    logic             busy;
    logic             setup;
    logic             sck_q;
    logic             ce_n_q;
    logic [NIB_W-1:0] nib_cnt;
    logic [31:0]      tx_sh;
    logic [31:0]      rx_sh;
    logic             in_data;

    assign in_data = (nib_cnt >= NIB_W'(RD_DATA_FIRST));

    // Control path with one setup clock before the first sck edge
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            busy    <= 1'b0;
            setup   <= 1'b0;
            sck_q   <= 1'b0;
            ce_n_q  <= 1'b1;
            nib_cnt <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!busy) begin
                if (start_i) begin
                    busy    <= 1'b1;
                    setup   <= 1'b1;
                    ce_n_q  <= 1'b0;
                    nib_cnt <= '0;
                end
            end else if (setup) begin
                setup <= 1'b0;
            end else if (!sck_q) begin
                sck_q <= 1'b1;
            end else begin
                sck_q <= 1'b0;
                if (nib_cnt == NIB_W'(RD_LAST_NIB)) begin
                    // Release chip select and report in the same clock
                    busy   <= 1'b0;
                    ce_n_q <= 1'b1;
                    done_o <= 1'b1;
                end else begin
                    nib_cnt <= nib_cnt + 1'b1;
                end
            end
        end
    end

    // Command and address shifter, one nibble per falling sck
    always_ff @(posedge clk_i) begin
        if (!busy && start_i) begin
            tx_sh <= {CMD_QUAD_READ, addr_i};
        end else if (busy && !setup && sck_q) begin
            tx_sh <= {tx_sh[27:0], 4'b0000};
        end
    end

    // Device drives on falling sck, so sample just before the next fall
    always_ff @(posedge clk_i) begin
        if (busy && !setup && sck_q && in_data) begin
            rx_sh <= {rx_sh[27:0], io.din};
        end
    end

    // First byte received lands in bits 7:0
    assign data_o = {rx_sh[7:0], rx_sh[15:8], rx_sh[23:16], rx_sh[31:24]};

    assign io.sck    = sck_q;
    assign io.ce_n   = ce_n_q;
    assign io.dout   = tx_sh[31:28];
    // Bus turns around after the address phase
    assign io.douten = busy && (nib_cnt < NIB_W'(CMD_NIBBLES + ADDR_NIBBLES));

endmodule

`default_nettype wire

//--- hw/psram_writer.sv
`timescale 1ns/1ps
`default_nettype none

// Quad write (38h) of one, two or four bytes
module psram_writer
    import psram_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [2:0]        size_i,
    input  logic [31:0]       data_i,
    output logic              done_o,
    psram_io_if.phy           io
);

    logic             busy;
    logic             setup;
    logic             sck_q;
    logic             ce_n_q;
    logic [NIB_W-1:0] nib_cnt;
    logic [NIB_W-1:0] last_nib;
    logic [63:0]      tx_sh;

    // Same sequencing as the reader, length set by the byte count
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            busy     <= 1'b0;
            setup    <= 1'b0;
            sck_q    <= 1'b0;
            ce_n_q   <= 1'b1;
            nib_cnt  <= '0;
            last_nib <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!busy) begin
                if (start_i) begin
                    busy     <= 1'b1;
                    setup    <= 1'b1;
                    ce_n_q   <= 1'b0;
                    nib_cnt  <= '0;
                    // Two nibbles per data byte
                    last_nib <= NIB_W'(CMD_NIBBLES + ADDR_NIBBLES - 1)
                                + NIB_W'({size_i, 1'b0});
                end
            end else if (setup) begin
                setup <= 1'b0;
            end else if (!sck_q) begin
                sck_q <= 1'b1;
            end else begin
                sck_q <= 1'b0;
                if (nib_cnt == last_nib) begin
                    busy   <= 1'b0;
                    ce_n_q <= 1'b1;
                    done_o <= 1'b1;
                end else begin
                    nib_cnt <= nib_cnt + 1'b1;
                end
            end
        end
    end

    // Byte 0 follows the address, high nibble first in every byte
    always_ff @(posedge clk_i) begin
        if (!busy && start_i) begin
            tx_sh <= {CMD_QUAD_WRITE, addr_i,
                      data_i[7:0], data_i[15:8], data_i[23:16], data_i[31:24]};
        end else if (busy && !setup && sck_q) begin
            tx_sh <= {tx_sh[59:0], 4'b0000};
        end
    end

    assign io.sck    = sck_q;
    assign io.ce_n   = ce_n_q;
    assign io.dout   = tx_sh[63:60];
    // Write never turns the bus around
    assign io.douten = busy;

endmodule

`default_nettype wire

//--- hw/psram_ctrl_wb.sv
`timescale 1ns/1ps
`default_nettype none

// Wishbone slave front end for a quad-SPI PSRAM
module psram_ctrl_wb
    import psram_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    input  logic [3:0]  sel_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    output logic        ack_o,

    output logic        sck_o,
    output logic        ce_n_o,
    input  logic [3:0]  din_i,
    output logic [3:0]  dout_o,
    output logic [3:0]  douten_o
);

    ctrl_state_t       state;
    logic              wb_valid;
    logic              init_done;
    logic              rd_start;
    logic              wr_start;
    logic              rd_done;
    logic              wr_done;
    logic              eng_done;
    logic              is_wr;
    logic [2:0]        wr_size;
    logic [1:0]        wr_lane;
    logic [31:0]       wr_data;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    psram_io_if io_init ();
    psram_io_if io_rd ();
    psram_io_if io_wr ();

    assign wb_valid = cyc_i && stb_i;
    assign eng_done = is_wr ? wr_done : rd_done;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state    <= ST_INIT;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            is_wr    <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                ST_INIT: begin
                    if (init_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (wb_valid) begin
                        state    <= ST_WAIT;
                        is_wr    <= we_i;
                        rd_start <= ~we_i;
                        wr_start <= we_i;
                    end
                end
                ST_WAIT: begin
                    if (eng_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    assign ack_o = (state == ST_WAIT) && eng_done;

    // Byte count and lowest lane from the byte selects
    always_comb begin
        case (sel_i)
            4'b0001: {wr_size, wr_lane} = {3'd1, 2'd0};
            4'b0010: {wr_size, wr_lane} = {3'd1, 2'd1};
            4'b0100: {wr_size, wr_lane} = {3'd1, 2'd2};
            4'b1000: {wr_size, wr_lane} = {3'd1, 2'd3};
            4'b0011: {wr_size, wr_lane} = {3'd2, 2'd0};
            4'b1100: {wr_size, wr_lane} = {3'd2, 2'd2};
            default: {wr_size, wr_lane} = {3'd4, 2'd0};
        endcase
    end

    // Selected bytes moved down to the low end
    assign wr_data = dat_i >> {wr_lane, 3'b000};
    assign wr_addr = {adr_i[ADDR_W-1:2], wr_lane};
    assign rd_addr = {adr_i[ADDR_W-1:2], 2'b00};

    psram_qpi_init u_init (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .io          (io_init),
        .init_done_o (init_done)
    );

    psram_reader u_reader (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (rd_start),
        .addr_i  (rd_addr),
        .done_o  (rd_done),
        .data_o  (dat_o),
        .io      (io_rd)
    );

    psram_writer u_writer (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (wr_start),
        .addr_i  (wr_addr),
        .size_i  (wr_size),
        .data_i  (wr_data),
        .done_o  (wr_done),
        .io      (io_wr)
    );

    // Incoming data reaches every driver
    assign io_init.din = din_i;
    assign io_rd.din   = din_i;
    assign io_wr.din   = din_i;

    // Pins follow init until it is done and then the engine of the accepted request
    always_comb begin
        if (!init_done) begin
            sck_o    = io_init.sck;
            ce_n_o   = io_init.ce_n;
            dout_o   = io_init.dout;
            douten_o = {4{io_init.douten}};
        end else if (is_wr) begin
            sck_o    = io_wr.sck;
            ce_n_o   = io_wr.ce_n;
            dout_o   = io_wr.dout;
            douten_o = {4{io_wr.douten}};
        end else begin
            sck_o    = io_rd.sck;
            ce_n_o   = io_rd.ce_n;
            dout_o   = io_rd.dout;
            douten_o = {4{io_rd.douten}};
        end
    end

endmodule

`default_nettype wire

//--- test/psram_model.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral quad PSRAM, serial until it receives the enter-quad command
module psram_model
    import psram_pkg::*;
(
    input  logic       sck_i,
    input  logic       ce_n_i,
    input  logic [3:0] dq_i,
    input  logic [3:0] dq_oe_i,
    output logic [3:0] dq_o,
    output logic       quad_early_o,
    output logic       proto_err_o
);

    logic [7:0]        mem [int];
    logic              quad_mode = 1'b0;
    logic              quad_early = 1'b0;
    logic              proto_err = 1'b0;
    logic [7:0]        cmd = 8'h00;
    logic [ADDR_W-1:0] addr = '0;
    logic [7:0]        wbyte = 8'h00;
    logic [7:0]        rd_byte = 8'h00;
    logic [3:0]        dq_q = 4'h0;
    int                bit_cnt = 0;
    int                nib_cnt = 0;
    int                data_nib = 0;

    // Bytes never written read back a pattern of their full address
    function automatic logic [7:0] read_byte(input logic [ADDR_W-1:0] a);
        if (mem.exists(int'(a))) begin
            return mem[int'(a)];
        end
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'hA5;
    endfunction

    // Sample on rising sck, counters cleared on deselect
    always @(posedge sck_i or posedge ce_n_i) begin
        if (ce_n_i) begin
            bit_cnt = 0;
            nib_cnt = 0;
        end else if (!quad_mode) begin
            cmd     = {cmd[6:0], dq_i[0]};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                // Anything but enter-quad here means quad traffic came too early
                if (cmd == CMD_QUAD_ENTER) begin
                    quad_mode = 1'b1;
                end else begin
                    quad_early = 1'b1;
                end
            end
        end else begin
            // Controller owns all four lines except during read dummy and data
            if ((nib_cnt < CMD_NIBBLES + ADDR_NIBBLES || cmd == CMD_QUAD_WRITE)
                && dq_oe_i != 4'hF) begin
                proto_err = 1'b1;
            end
            if (nib_cnt >= CMD_NIBBLES + ADDR_NIBBLES && cmd == CMD_QUAD_READ
                && dq_oe_i != 4'h0) begin
                proto_err = 1'b1;
            end
            if (nib_cnt < CMD_NIBBLES) begin
                cmd = {cmd[3:0], dq_i};
            end else if (nib_cnt < CMD_NIBBLES + ADDR_NIBBLES) begin
                if (nib_cnt == CMD_NIBBLES && cmd != CMD_QUAD_READ
                    && cmd != CMD_QUAD_WRITE) begin
                    proto_err = 1'b1;
                end
                addr = {addr[ADDR_W-5:0], dq_i};
            end else if (cmd == CMD_QUAD_WRITE) begin
                wbyte = {wbyte[3:0], dq_i};
                // Low nibble completes the byte
                if (nib_cnt % 2 == 1) begin
                    mem[int'(addr)] = wbyte;
                    addr = addr + 1'b1;
                end
            end
            nib_cnt = nib_cnt + 1;
        end
    end

    // Read data goes out on falling sck, one nibble ahead of its sample
    always @(negedge sck_i) begin
        if (!ce_n_i && quad_mode && cmd == CMD_QUAD_READ
            && nib_cnt >= RD_DATA_FIRST && nib_cnt <= RD_LAST_NIB) begin
            data_nib = nib_cnt - RD_DATA_FIRST;
            rd_byte  = read_byte(addr + ADDR_W'(data_nib / 2));
            dq_q     = (data_nib % 2 == 0) ? rd_byte[7:4] : rd_byte[3:0];
        end
    end

    assign dq_o         = dq_q;
    assign quad_early_o = quad_early;
    assign proto_err_o  = proto_err;

endmodule

`default_nettype wire

//--- test/tb_psram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_psram_ctrl
    import psram_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int POOL_WORDS    = 16;
    localparam int RANDOM_OPS    = 200;
    localparam int TOTAL_OPS     = 2 * POOL_WORDS + 16 + 8 + RANDOM_OPS;
    localparam int INIT_CYCLES   = RESET_CYCLES + 2 * INIT_BITS + 4;
    localparam int CYCLES_PER_OP = 60;
    localparam int ACK_LIMIT     = 100;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic [3:0]  wb_sel;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_ack;
    logic        sck;
    logic        ce_n;
    logic [3:0]  dq_in;
    logic [3:0]  dq_out;
    logic [3:0]  dq_oe;
    logic        quad_early;
    logic        proto_err;

    logic [7:0]  shadow [int];
    logic [31:0] rng_state;
    logic        init_over = 1'b0;
    int          ack_count = 0;
    int          requests = 0;
    int          data_errors = 0;
    int          protocol_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    psram_ctrl_wb psram_ctrl_wb_i (
        .clk_i    (clk),
        .rst_i    (rst),
        .adr_i    (wb_adr),
        .dat_i    (wb_dat_w),
        .dat_o    (wb_dat_r),
        .sel_i    (wb_sel),
        .cyc_i    (wb_cyc),
        .stb_i    (wb_stb),
        .we_i     (wb_we),
        .ack_o    (wb_ack),
        .sck_o    (sck),
        .ce_n_o   (ce_n),
        .din_i    (dq_in),
        .dout_o   (dq_out),
        .douten_o (dq_oe)
    );

    psram_model u_model (
        .sck_i        (sck),
        .ce_n_i       (ce_n),
        .dq_i         (dq_out),
        .dq_oe_i      (dq_oe),
        .dq_o         (dq_in),
        .quad_early_o (quad_early),
        .proto_err_o  (proto_err)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Word addresses spread over the whole device
    function automatic logic [31:0] pool_addr(input int idx);
        return (idx * 32'h0010_0104) & 32'h00FF_FFFC;
    endfunction

    function automatic int word_base(input logic [31:0] adr);
        return int'(adr[ADDR_W-1:2]) * 4;
    endfunction

    function automatic logic [3:0] legal_sel(input logic [2:0] k);
        case (k)
            3'd0: return 4'b0001;
            3'd1: return 4'b0010;
            3'd2: return 4'b0100;
            3'd3: return 4'b1000;
            3'd4: return 4'b0011;
            3'd5: return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            data_errors++;
            $display("Error %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    // One Wishbone request, held until acknowledged
    task automatic issue_request(input string test_name, input logic is_write,
                                 input logic [31:0] adr, input logic [31:0] data,
                                 input logic [3:0] sel, output logic [31:0] rdata);
        int   waited;
        int   acks_before;
        logic ack_seen;
        waited      = 0;
        ack_seen    = 1'b0;
        acks_before = ack_count;
        rdata       = '0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= is_write;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wb_sel   <= sel;
        while (!ack_seen && waited < ACK_LIMIT) begin
            @(negedge clk);
            ack_seen = wb_ack;
            rdata    = wb_dat_r;
            waited++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        assert (ack_seen) else begin
            protocol_errors++;
            $display("%s: request at %h got no acknowledge in %0d cycles",
                     test_name, adr, ACK_LIMIT);
        end
        assert (ack_count == acks_before + 1) else begin
            protocol_errors++;
            $display("Error %s: expected 1 acknowledge, actual %0d",
                     test_name, ack_count - acks_before);
        end
        requests++;
    endtask

    task automatic write_lanes(input string test_name, input logic [31:0] adr,
                               input logic [31:0] data, input logic [3:0] sel);
        logic [31:0] ignored;
        int          base;
        issue_request(test_name, 1'b1, adr, data, sel, ignored);
        base = word_base(adr);
        // Lane k of the bus lands at byte address base + k
        for (int k = 0; k < 4; k++) begin
            if (sel[k]) begin
                shadow[base + k] = data[8*k +: 8];
            end
        end
    endtask

    task automatic read_check(input string test_name, input logic [31:0] adr);
        logic [31:0] got;
        logic [31:0] expected;
        int          base;
        issue_request(test_name, 1'b0, adr, 32'h0, 4'hF, got);
        base     = word_base(adr);
        expected = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
        check_value(test_name, expected, got);
    endtask

    // Bus monitor, sampled away from the driving edge
    always @(negedge clk) begin
        if (wb_ack) begin
            ack_count++;
            assert (wb_cyc && wb_stb) else begin
                protocol_errors++;
                $display("Acknowledge seen with no request pending");
            end
        end
        if (init_over && !(wb_cyc && wb_stb)) begin
            assert (ce_n) else begin
                protocol_errors++;
                $display("Chip select low between transactions");
            end
        end
        if (!rst && ce_n) begin
            init_over = 1'b1;
        end
    end

    initial begin
        #(CLK_PERIOD * (INIT_CYCLES + TOTAL_OPS * CYCLES_PER_OP));
        $display("Watchdog expired before the tests completed");
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] adr;
        rng_state = 32'd60;
        rst      = 1'b1;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // First request lands while the enter-quad command is still going out
        write_lanes("init", pool_addr(0), next_random(), 4'hF);
        for (int i = 1; i < POOL_WORDS; i++) begin
            write_lanes("full_word", pool_addr(i), next_random(), 4'hF);
        end
        for (int i = 0; i < POOL_WORDS; i++) begin
            read_check("full_word", pool_addr(i));
        end

        for (int a = 2; a < 8; a += 5) begin
            for (int lane = 0; lane < 4; lane++) begin
                write_lanes("byte_lane", pool_addr(a), next_random(), 4'b0001 << lane);
                read_check("byte_lane", pool_addr(a));
            end
        end

        for (int a = 4; a < 12; a += 7) begin
            write_lanes("halfword", pool_addr(a), next_random(), 4'b0011);
            read_check("halfword", pool_addr(a));
            write_lanes("halfword", pool_addr(a), next_random(), 4'b1100);
            read_check("halfword", pool_addr(a));
        end

        // Low address bits are random too, the word is always aligned
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r   = next_random();
            adr = pool_addr(int'(r[3:0])) | {30'b0, r[5:4]};
            if (r[6]) begin
                write_lanes("random", adr, next_random(), legal_sel(r[9:7]));
            end else begin
                read_check("random", adr);
            end
        end

        assert (!quad_early) else begin
            protocol_errors++;
            $display("Quad command reached the device before enter-quad");
        end
        assert (!proto_err) else begin
            protocol_errors++;
            $display("Device model saw a malformed quad transfer");
        end
        assert (init_over) else begin
            protocol_errors++;
            $display("Chip select never returned high after init");
        end

        $display("Summary: %0d requests, %0d data errors, %0d protocol errors",
                 requests, data_errors, protocol_errors);
        if (data_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/psram_pkg.sv
hw/psram_io_if.sv
hw/psram_qpi_init.sv
hw/psram_reader.sv
hw/psram_writer.sv
hw/psram_ctrl_wb.sv
test/psram_model.sv
test/tb_psram_ctrl.sv

//--- Makefile
# Verilator build and run for the PSRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_psram_ctrl
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the run output holds the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
